// File: Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lsu_pkg.sv
      - verilog/lsu_lane_plan.sv
      - verilog/lsu_read_fsm.sv
      - verilog/lsu_write_fsm.sv
      - verilog/lsu_load_merge.sv
      - verilog/lsu_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/lsu_chk.sv
      - bench/lsu_tb.sv

// File: bench/lsu_chk.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_chk (
	input wire                  clock,
	input wire                  reset,
	input wire                  arvalid,
	input wire [`LSU_XLEN-1:0]  araddr,
	input wire                  arready,
	input wire                  awvalid,
	input wire [`LSU_XLEN-1:0]  awaddr,
	input wire                  awready,
	input wire                  wvalid,
	input wire [`LSU_BUS_W-1:0] wdata,
	input wire [`LSU_LANES-1:0] wstrb,
	input wire                  wready,
	input wire                  retire,
	input wire                  regfile_wen
);

	int   errors = 0;
	logic aw_taken;

	// address of the current write beat has been accepted
	always_ff @(posedge clock) begin
		if (reset) begin
			aw_taken <= 1'b0;
		end else if (awvalid && awready) begin
			aw_taken <= 1'b1;
		end else if (wvalid && wready) begin
			aw_taken <= 1'b0;
		end
	end

	// ------------------------------
	// channel stability
	// ------------------------------
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			$error("read address dropped or changed before arready");
			errors++;
		end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			$error("write address dropped or changed before awready");
			errors++;
		end

	w_hold: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else begin
			$error("write data dropped or changed before wready");
			errors++;
		end

	// ------------------------------
	// ordering
	// ------------------------------
	w_after_aw: assert property (@(posedge clock) disable iff (reset)
		wvalid |-> aw_taken)
		else begin
			$error("wvalid raised before the write address handshake");
			errors++;
		end

	wen_at_retire: assert property (@(posedge clock) disable iff (reset)
		regfile_wen |-> retire)
		else begin
			$error("register write outside a retire cycle");
			errors++;
		end

endmodule

bind lsu_top lsu_chk u_chk (
	.clock       (clock),
	.reset       (reset),
	.arvalid     (arvalid),
	.araddr      (araddr),
	.arready     (arready),
	.awvalid     (awvalid),
	.awaddr      (awaddr),
	.awready     (awready),
	.wvalid      (wvalid),
	.wdata       (wdata),
	.wstrb       (wstrb),
	.wready      (wready),
	.retire      (retire),
	.regfile_wen (regfile_wen)
);

`default_nettype wire

// File: bench/lsu_tb.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_tb;
	import lsu_pkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam int RANDOM_REQS = 400;

	// one expected bus beat, id points into req_names
	typedef struct packed {
		int                    id;
		logic [`LSU_XLEN-1:0]  addr;
		logic [`LSU_LANES-1:0] strb;
		logic [2:0]            size;
		bus_word_u             data;
	} beat_exp_t;

	typedef struct packed {
		int                   id;
		lsu_req_t             req;
		logic                 wen;
		logic [`LSU_XLEN-1:0] data;
	} retire_exp_t;

	logic                  clock;
	logic                  reset;
	logic                  in_valid;
	lsu_req_t              in_req;
	logic                  in_allowin;
	logic                  retire;
	logic                  regfile_wen;
	logic [`LSU_REG_W-1:0] regfile_waddr;
	logic [`LSU_XLEN-1:0]  regfile_wdata;
	logic                  arvalid;
	logic [`LSU_XLEN-1:0]  araddr;
	logic [2:0]            arsize;
	logic                  arready;
	logic                  rvalid;
	logic [`LSU_BUS_W-1:0] rdata;
	logic                  rready;
	logic                  awvalid;
	logic [`LSU_XLEN-1:0]  awaddr;
	logic [2:0]            awsize;
	logic                  awready;
	logic                  wvalid;
	logic [`LSU_BUS_W-1:0] wdata;
	logic [`LSU_LANES-1:0] wstrb;
	logic                  wready;
	logic                  bvalid;
	logic                  bready;

	logic [31:0]          rng;
	logic [7:0]           bus_mem [0:255];
	logic [7:0]           ref_mem [0:255];
	string                req_names[$];
	beat_exp_t            exp_rd[$];
	beat_exp_t            exp_wr[$];
	beat_exp_t            w_pend[$];
	logic [`LSU_XLEN-1:0] rd_pend[$];
	retire_exp_t          exp_ret[$];
	int                   ar_delay;
	int                   r_delay;
	int                   aw_delay;
	int                   w_delay;
	int                   b_delay;
	int                   b_pend;
	int                   accepted;
	int                   retired;

	lsu_top u_lsu_top (
		.clock         (clock),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_req        (in_req),
		.in_allowin    (in_allowin),
		.retire        (retire),
		.regfile_wen   (regfile_wen),
		.regfile_waddr (regfile_waddr),
		.regfile_wdata (regfile_wdata),
		.arvalid       (arvalid),
		.araddr        (araddr),
		.arsize        (arsize),
		.arready       (arready),
		.rvalid        (rvalid),
		.rdata         (rdata),
		.rready        (rready),
		.awvalid       (awvalid),
		.awaddr        (awaddr),
		.awsize        (awsize),
		.awready       (awready),
		.wvalid        (wvalid),
		.wdata         (wdata),
		.wstrb         (wstrb),
		.wready        (wready),
		.bvalid        (bvalid),
		.bready        (bready)
	);

	always #20 clock = ~clock;

	// ------------------------------
	// random numbers
	// ------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// ready and response delays of 0 to 3 cycles
	function automatic int rand_delay();
		logic [31:0] r;
		r = next_rand();
		return int'(r[1:0]);
	endfunction

	// ------------------------------
	// reporting and compare tasks
	// ------------------------------
	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_reg(input string name, input lsu_req_t req, input logic exp_wen,
			input logic [`LSU_XLEN-1:0] exp_data, input logic act_wen,
			input logic [`LSU_REG_W-1:0] act_waddr, input logic [`LSU_XLEN-1:0] act_data);
		if (act_wen !== exp_wen ||
				(exp_wen && (act_waddr !== req.rd || act_data !== exp_data))) begin
			$display("CHECK FAILED %s: expected wen=%0b x%0d=%h, actual wen=%0b x%0d=%h",
				name, exp_wen, req.rd, exp_data, act_wen, act_waddr, act_data);
			fail_now("register write differs from the model");
		end
	endtask

	task automatic check_beat(input string name, input logic [`LSU_XLEN-1:0] exp_addr,
			input logic [2:0] exp_size, input logic [`LSU_XLEN-1:0] act_addr,
			input logic [2:0] act_size);
		if (act_addr !== exp_addr || act_size !== exp_size) begin
			$display("CHECK FAILED %s: expected addr=%h size=%0d, actual addr=%h size=%0d",
				name, exp_addr, exp_size, act_addr, act_size);
			fail_now("bus beat differs from the model");
		end
	endtask

	task automatic check_lanes(input string name, input logic [`LSU_LANES-1:0] exp_strb,
			input bus_word_u exp_data, input logic [`LSU_LANES-1:0] act_strb,
			input bus_word_u act_data);
		logic bad;
		int   l;
		bad = act_strb !== exp_strb;
		for (l = 0; l < `LSU_LANES; l++) begin
			if (exp_strb[l] && act_data.lanes[l] !== exp_data.lanes[l]) begin
				bad = 1'b1;
			end
		end
		if (bad) begin
			$display("CHECK FAILED %s: expected strb=%h data=%h, actual strb=%h data=%h",
				name, exp_strb, exp_data.flat, act_strb, act_data.flat);
			fail_now("write data differs from the model");
		end
	endtask

	task automatic check_count(input string name, input int exp_n, input int act_n);
		if (act_n != exp_n) begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, exp_n, act_n);
			fail_now("count differs from the model");
		end
	endtask

	// ------------------------------
	// bus memory model
	// ------------------------------
	function automatic bus_word_u read_word(input logic [`LSU_XLEN-1:0] addr);
		bus_word_u w;
		int        l;
		for (l = 0; l < `LSU_LANES; l++) begin
			w.lanes[l] = bus_mem[{addr[7:3], l[2:0]}];
		end
		return w;
	endfunction

	// handshakes are decided here, they complete on the next rising edge
	task automatic serve_read();
		beat_exp_t e;
		bus_word_u w;
		arready = 1'b0;
		if (arvalid) begin
			if (ar_delay == 0) begin
				if (exp_rd.size() == 0) begin
					fail_now("read address beat that no request asked for");
				end
				e = exp_rd.pop_front();
				check_beat($sformatf("%s read address", req_names[e.id]),
					e.addr, e.size, araddr, arsize);
				rd_pend.push_back(araddr);
				arready = 1'b1;
				ar_delay = rand_delay();
			end else begin
				ar_delay--;
			end
		end
		rvalid = 1'b0;
		if (rready && rd_pend.size() != 0) begin
			if (r_delay == 0) begin
				w = read_word(rd_pend.pop_front());
				rdata = w.flat;
				rvalid = 1'b1;
				r_delay = rand_delay();
			end else begin
				r_delay--;
			end
		end
	endtask

	task automatic serve_write();
		beat_exp_t e;
		bus_word_u act;
		int        l;
		awready = 1'b0;
		if (awvalid) begin
			if (aw_delay == 0) begin
				if (exp_wr.size() == 0) begin
					fail_now("write address beat that no request asked for");
				end
				e = exp_wr.pop_front();
				check_beat($sformatf("%s write address", req_names[e.id]),
					e.addr, e.size, awaddr, awsize);
				w_pend.push_back(e);
				awready = 1'b1;
				aw_delay = rand_delay();
			end else begin
				aw_delay--;
			end
		end
		wready = 1'b0;
		if (wvalid) begin
			if (w_delay == 0) begin
				if (w_pend.size() == 0) begin
					fail_now("write data beat without a write address");
				end
				e = w_pend.pop_front();
				act.flat = wdata;
				check_lanes($sformatf("%s write data", req_names[e.id]),
					e.strb, e.data, wstrb, act);
				for (l = 0; l < `LSU_LANES; l++) begin
					if (wstrb[l]) begin
						bus_mem[{e.addr[7:3], l[2:0]}] = act.lanes[l];
					end
				end
				b_pend++;
				wready = 1'b1;
				w_delay = rand_delay();
			end else begin
				w_delay--;
			end
		end
		bvalid = 1'b0;
		if (bready && b_pend != 0) begin
			if (b_delay == 0) begin
				bvalid = 1'b1;
				b_pend--;
				b_delay = rand_delay();
			end else begin
				b_delay--;
			end
		end
	endtask

	task automatic watch_retire();
		retire_exp_t r;
		if (retire) begin
			if (exp_ret.size() == 0) begin
				fail_now("retire with no request outstanding");
			end
			r = exp_ret.pop_front();
			check_reg(req_names[r.id], r.req, r.wen, r.data,
				regfile_wen, regfile_waddr, regfile_wdata);
			retired++;
		end
	endtask

	// one clock cycle, everything sampled and driven at the falling edge
	task automatic cycle();
		@(negedge clock);
		if (u_lsu_top.u_chk.errors != 0) begin
			fail_now("a bus protocol assertion failed");
		end
		watch_retire();
		serve_read();
		serve_write();
	endtask

	// ------------------------------
	// reference model and stimulus
	// ------------------------------

	// bytes up to the 4-byte boundary go in the first beat, the rest in the second
	task automatic expect_beats(input int id, input logic [`LSU_XLEN-1:0] addr, input int n,
			input logic is_load, input logic [`LSU_XLEN-1:0] sdata);
		beat_exp_t            b0;
		beat_exp_t            b1;
		logic [`LSU_XLEN-1:0] a;
		logic                 split;
		int                   i;
		b0 = '0;
		b1 = '0;
		b0.id = id;
		b1.id = id;
		b0.addr = addr;
		b0.size = (n == 4) ? `LSU_SIZE_W : ((n == 2) ? `LSU_SIZE_H : `LSU_SIZE_B);
		b1.size = b0.size;
		split = 1'b0;
		for (i = 0; i < n; i++) begin
			a = addr + i;
			if (a[`LSU_XLEN-1:2] == addr[`LSU_XLEN-1:2]) begin
				b0.strb[a[2:0]] = 1'b1;
				b0.data.lanes[a[2:0]] = sdata[8*i +: 8];
			end else begin
				// second beat starts at the first byte past the boundary
				if (!split) begin
					b1.addr = a;
				end
				split = 1'b1;
				b1.strb[a[2:0]] = 1'b1;
				b1.data.lanes[a[2:0]] = sdata[8*i +: 8];
			end
		end
		if (is_load) begin
			exp_rd.push_back(b0);
			if (split) begin
				exp_rd.push_back(b1);
			end
		end else begin
			exp_wr.push_back(b0);
			if (split) begin
				exp_wr.push_back(b1);
			end
		end
	endtask

	// sel 0..7 is lw, lh, lhu, lb, lbu, sw, sh, sb
	task automatic issue(input string name, input int sel, input logic [`LSU_XLEN-1:0] addr,
			input logic [`LSU_XLEN-1:0] sdata, input logic [`LSU_REG_W-1:0] rd);
		lsu_req_t             req;
		retire_exp_t          r;
		logic [`LSU_XLEN-1:0] off;
		logic [`LSU_XLEN-1:0] value;
		logic [7:0]           a8;
		logic                 is_load;
		int                   n;
		int                   i;
		int                   waited;
		off = (next_rand() & 32'h3f) - 32'd32;
		req.base = addr - off;
		req.offset = off;
		req.store_data = sdata;
		req.rd = rd;
		req.kind = '0;
		case (sel)
			0: req.kind.lw = 1'b1;
			1: req.kind.lh = 1'b1;
			2: req.kind.lhu = 1'b1;
			3: req.kind.lb = 1'b1;
			4: req.kind.lbu = 1'b1;
			5: req.kind.sw = 1'b1;
			6: req.kind.sh = 1'b1;
			default: req.kind.sb = 1'b1;
		endcase
		is_load = sel < 5;
		n = (sel == 0 || sel == 5) ? 4 : ((sel == 1 || sel == 2 || sel == 6) ? 2 : 1);
		req_names.push_back(name);
		expect_beats(req_names.size() - 1, addr, n, is_load, sdata);

		// little-endian bytes, window wraps at 256
		value = '0;
		for (i = 0; i < n; i++) begin
			a8 = addr[7:0] + i[7:0];
			if (is_load) begin
				value[8*i +: 8] = ref_mem[a8];
			end else begin
				ref_mem[a8] = sdata[8*i +: 8];
			end
		end
		if (sel == 1) begin
			value = {{16{value[15]}}, value[15:0]};
		end else if (sel == 3) begin
			value = {{24{value[7]}}, value[7:0]};
		end
		r.id = req_names.size() - 1;
		r.req = req;
		r.wen = is_load;
		r.data = value;
		exp_ret.push_back(r);

		in_valid = 1'b1;
		in_req = req;
		waited = 0;
		while (in_allowin !== 1'b1) begin
			cycle();
			waited++;
			if (waited > WAIT_LIMIT) begin
				fail_now($sformatf("%s was not accepted in time", name));
			end
		end
		if (accepted != retired) begin
			fail_now("a second request was accepted before the pending one retired");
		end
		accepted++;
		cycle();
		in_valid = 1'b0;
	endtask

	initial begin
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [31:0] sdata;
		logic [7:0]  fill;
		int          i;
		int          sel;
		int          gap;
		int          waited;
		clock = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_req = '0;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		rng = 32'hb449e7e7;
		accepted = 0;
		retired = 0;
		b_pend = 0;
		for (i = 0; i < 256; i++) begin
			fill = i[7:0] * 8'd37 + 8'd11;
			bus_mem[i] = fill;
			ref_mem[i] = fill;
		end
		ar_delay = rand_delay();
		r_delay = rand_delay();
		aw_delay = rand_delay();
		w_delay = rand_delay();
		b_delay = rand_delay();

		for (i = 0; i < 8; i++) begin
			@(negedge clock);
		end
		reset = 1'b0;
		cycle();
		if (retire !== 1'b0 || regfile_wen !== 1'b0 || arvalid !== 1'b0 ||
				rready !== 1'b0 || awvalid !== 1'b0 || wvalid !== 1'b0 ||
				bready !== 1'b0 || in_allowin !== 1'b1) begin
			fail_now("outputs are not idle after reset");
		end

		// aligned loads
		issue("aligned lw", 0, 32'h8000_0040, 32'h0, 5'd1);
		issue("aligned lh", 1, 32'h8000_0046, 32'h0, 5'd2);
		issue("aligned lhu", 2, 32'h8000_004a, 32'h0, 5'd3);
		issue("aligned lb", 3, 32'h8000_004d, 32'h0, 5'd4);
		issue("aligned lbu", 4, 32'h8000_0043, 32'h0, 5'd5);

		// loads across a 4-byte boundary
		issue("split lw +1", 0, 32'h8000_0051, 32'h0, 5'd6);
		issue("split lw +2", 0, 32'h8000_0056, 32'h0, 5'd7);
		issue("split lw +3", 0, 32'h8000_005b, 32'h0, 5'd8);
		issue("split lh +3", 1, 32'h8000_0063, 32'h0, 5'd9);
		issue("split lhu +3", 2, 32'h8000_0067, 32'h0, 5'd10);
		issue("wrapping lw", 0, 32'h8000_00fe, 32'h0, 5'd11);

		// stores, then read them back
		issue("aligned sw", 5, 32'h8000_0080, 32'h1234_5678, 5'd0);
		issue("split sw", 5, 32'h8000_0085, 32'h89ab_cdef, 5'd0);
		issue("aligned sh", 6, 32'h8000_0088, 32'h0000_8a5c, 5'd0);
		issue("split sh", 6, 32'h8000_008b, 32'h0000_f00d, 5'd0);
		issue("aligned sb", 7, 32'h8000_0091, 32'h0000_00c3, 5'd0);
		issue("readback lw", 0, 32'h8000_0080, 32'h0, 5'd12);
		issue("readback split lw", 0, 32'h8000_0085, 32'h0, 5'd13);
		issue("readback split lh", 1, 32'h8000_008b, 32'h0, 5'd14);
		issue("readback lb", 3, 32'h8000_0091, 32'h0, 5'd15);

		// random mix in a 256-byte window
		for (i = 0; i < RANDOM_REQS; i++) begin
			rnd = next_rand();
			sel = int'(rnd[2:0]);
			addr = 32'h8000_0000 | (next_rand() & 32'hff);
			sdata = next_rand();
			rnd = next_rand();
			issue($sformatf("random %0d", i), sel, addr, sdata, rnd[4:0]);
			gap = int'(rnd[9:8]);
			while (gap > 0) begin
				cycle();
				gap--;
			end
		end

		// unit is free again once it will take a new request
		waited = 0;
		while (in_allowin !== 1'b1) begin
			cycle();
			waited++;
			if (waited > WAIT_LIMIT) begin
				fail_now("the last request did not finish in time");
			end
		end
		for (i = 0; i < 4; i++) begin
			cycle();
		end
		check_count("retire count", accepted, retired);
		check_count("leftover read beats", 0, exp_rd.size());
		check_count("leftover write beats", 0, exp_wr.size());
		if (u_lsu_top.u_chk.errors == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			fail_now("a bus protocol assertion failed");
		end
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_lane_plan.sv
verilog/lsu_read_fsm.sv
verilog/lsu_write_fsm.sv
verilog/lsu_load_merge.sv
verilog/lsu_top.sv
bench/lsu_chk.sv
bench/lsu_tb.sv

// File: verilog/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// ------------------------------
// widths
// ------------------------------

// register and address width
`define LSU_XLEN 32

// bus data width and its byte lanes
`define LSU_BUS_W 64
`define LSU_LANES 8

// register index
`define LSU_REG_W 5

// ------------------------------
// bus size codes
// ------------------------------
`define LSU_SIZE_B 3'd0
`define LSU_SIZE_H 3'd1
`define LSU_SIZE_W 3'd2

`endif

// File: verilog/lsu_lane_plan.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_lane_plan (
	input  wire lsu_pkg::lsu_req_t   req,
	output lsu_pkg::beat_plan_t      plan
);
	import lsu_pkg::*;

	logic [`LSU_XLEN-1:0]    addr;
	logic                    is_word;
	logic                    is_half;
	logic [3:0]              mask;
	logic [7:0]              span;
	logic                    split;
	logic [2:0]              size;
	logic [5:0]              shamt;
	logic [2*`LSU_BUS_W-1:0] doubled;
	bus_word_u               wdata_rot;

	// ------------------------------
	// address and access width
	// ------------------------------
	assign addr = req.base + req.offset;

	assign is_word = req.kind.lw | req.kind.sw;
	assign is_half = req.kind.lh | req.kind.lhu | req.kind.sh;

	// bytes touched, relative to the 4-byte group
	assign mask = is_word ? 4'b1111 : (is_half ? 4'b0011 : 4'b0001);

	// low nibble stays in this group, high nibble spills into the next
	assign span = {4'b0000, mask} << addr[1:0];

	// word unless aligned, half only at offset 3
	assign split = (is_word && addr[1:0] != 2'd0) ||
		(is_half && addr[1:0] == 2'd3);

	assign size = is_word ? `LSU_SIZE_W : (is_half ? `LSU_SIZE_H : `LSU_SIZE_B);

	// ------------------------------
	// write data
	// ------------------------------

	// rotate left by whole bytes, so byte i lands in lane (addr + i) mod 8
	assign shamt = {addr[2:0], 3'b000};
	assign doubled = {2{{`LSU_XLEN'd0, req.store_data}}} << shamt;

	always_comb begin
		wdata_rot.flat = doubled[2*`LSU_BUS_W-1:`LSU_BUS_W];
	end

	// ------------------------------
	// beat plan
	// ------------------------------
	always_comb begin
		plan.first_addr = addr;

		// next 4-byte boundary, carry ripples into the upper bits
		plan.second_addr = {addr[`LSU_XLEN-1:2] + 1'b1, 2'b00};

		// first beat stays in the half of the bus selected by addr[2]
		if (addr[2]) begin
			plan.first_strb = {span[3:0], 4'b0000};
		end else begin
			plan.first_strb = {4'b0000, span[3:0]};
		end

		// spilled bytes sit in the other half, lane of the next aligned address
		if (!split) begin
			plan.second_strb = 8'h00;
		end else if (addr[2]) begin
			plan.second_strb = {4'b0000, span[7:4]};
		end else begin
			plan.second_strb = {span[7:4], 4'b0000};
		end

		plan.size = size;
		plan.need_second = split;
		plan.wdata = wdata_rot;
	end

endmodule

`default_nettype wire

// File: verilog/lsu_load_merge.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_load_merge (
	input  wire lsu_pkg::lsu_kind_t   kind,
	input  wire lsu_pkg::beat_plan_t  plan,
	input  wire lsu_pkg::bus_word_u   first_beat,
	input  wire lsu_pkg::bus_word_u   last_beat,
	output logic [`LSU_XLEN-1:0]      load_data
);

	logic [3:0][7:0]        grouped;
	logic [2*`LSU_XLEN-1:0] pair;
	logic [`LSU_XLEN-1:0]   aligned;

	// ------------------------------
	// gather lanes
	// ------------------------------

	// lane i folds onto byte i mod 4; the two strobes never share a slot
	always_comb begin
		grouped = '0;
		for (int i = 0; i < `LSU_LANES; i++) begin
			if (plan.first_strb[i]) begin
				grouped[i % 4] = grouped[i % 4] | first_beat.lanes[i];
			end
			if (plan.second_strb[i]) begin
				grouped[i % 4] = grouped[i % 4] | last_beat.lanes[i];
			end
		end
	end

	// lowest address to byte 0
	assign pair = {grouped, grouped} >> {plan.first_addr[1:0], 3'b000};
	assign aligned = pair[`LSU_XLEN-1:0];

	// ------------------------------
	// extend
	// ------------------------------
	always_comb begin
		if (kind.lh) begin
			load_data = {{16{aligned[15]}}, aligned[15:0]};
		end else if (kind.lhu) begin
			load_data = {16'h0000, aligned[15:0]};
		end else if (kind.lb) begin
			load_data = {{24{aligned[7]}}, aligned[7:0]};
		end else if (kind.lbu) begin
			load_data = {24'h000000, aligned[7:0]};
		end else begin
			load_data = aligned;
		end
	end

endmodule

`default_nettype wire

// File: verilog/lsu_pkg.sv
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

	// one-hot access kind, exactly one bit set per request
	typedef struct packed {
		logic lw;
		logic lh;
		logic lhu;
		logic lb;
		logic lbu;
		logic sw;
		logic sh;
		logic sb;
	} lsu_kind_t;

	typedef struct packed {
		logic [`LSU_XLEN-1:0]  base;
		logic [`LSU_XLEN-1:0]  offset;
		logic [`LSU_XLEN-1:0]  store_data;
		logic [`LSU_REG_W-1:0] rd;
		lsu_kind_t             kind;
	} lsu_req_t;

	// one bus word, flat or by byte lane
	typedef union packed {
		logic [`LSU_BUS_W-1:0]      flat;
		logic [`LSU_LANES-1:0][7:0] lanes;
	} bus_word_u;

	// everything both FSMs and the load merge need for one request
	typedef struct packed {
		logic [`LSU_XLEN-1:0]  first_addr;
		logic [`LSU_XLEN-1:0]  second_addr;
		logic [`LSU_LANES-1:0] first_strb;
		logic [`LSU_LANES-1:0] second_strb;
		logic [2:0]            size;
		logic                  need_second;
		bus_word_u             wdata;
	} beat_plan_t;

endpackage

`default_nettype wire

// File: verilog/lsu_read_fsm.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_read_fsm (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       start,
	input  wire lsu_pkg::beat_plan_t  plan,
	input  wire                       arready,
	input  wire                       rvalid,
	input  wire [`LSU_BUS_W-1:0]      rdata,
	output logic                      arvalid,
	output logic [`LSU_XLEN-1:0]      araddr,
	output logic [2:0]                arsize,
	output logic                      rready,
	output lsu_pkg::bus_word_u        first_beat,
	output lsu_pkg::bus_word_u        last_beat,
	output logic                      done
);

	typedef enum logic [1:0] {
		rd_idle,
		rd_addr,
		rd_resp,
		rd_second
	} rd_state_t;

	rd_state_t state;
	logic      second;
	logic      last;

	assign last = !plan.need_second || second;

	// rready is always high in rd_resp
	assign done = (state == rd_resp) && rvalid && last;

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= rd_idle;
			arvalid <= 1'b0;
			rready <= 1'b0;
			second <= 1'b0;
		end else begin
			case (state)
				rd_idle: if (start) begin
					arvalid <= 1'b1;
					second <= 1'b0;
					state <= rd_addr;
				end
				rd_addr: if (arready) begin
					arvalid <= 1'b0;
					rready <= 1'b1;
					state <= rd_resp;
				end
				rd_resp: if (rvalid) begin
					rready <= 1'b0;
					state <= last ? rd_idle : rd_second;
				end
				// first beat is finished, go for the spilled bytes
				rd_second: begin
					arvalid <= 1'b1;
					second <= 1'b1;
					state <= rd_addr;
				end
				default: state <= rd_idle;
			endcase
		end
	end

	// ------------------------------
	// address and captured beats
	// ------------------------------
	always_ff @(posedge clock) begin
		if (state == rd_idle && start) begin
			araddr <= plan.first_addr;
			arsize <= plan.size;
		end else if (state == rd_second) begin
			araddr <= plan.second_addr;
		end
		if (state == rd_resp && rvalid) begin
			last_beat.flat <= rdata;
			if (!second) begin
				first_beat.flat <= rdata;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/lsu_top.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_top (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      in_valid,
	input  wire lsu_pkg::lsu_req_t   in_req,
	output logic                     in_allowin,
	output logic                     retire,
	output logic                     regfile_wen,
	output logic [`LSU_REG_W-1:0]    regfile_waddr,
	output logic [`LSU_XLEN-1:0]     regfile_wdata,
	output logic                     arvalid,
	output logic [`LSU_XLEN-1:0]     araddr,
	output logic [2:0]               arsize,
	input  wire                      arready,
	input  wire                      rvalid,
	input  wire [`LSU_BUS_W-1:0]     rdata,
	output logic                     rready,
	output logic                     awvalid,
	output logic [`LSU_XLEN-1:0]     awaddr,
	output logic [2:0]               awsize,
	input  wire                      awready,
	output logic                     wvalid,
	output logic [`LSU_BUS_W-1:0]    wdata,
	output logic [`LSU_LANES-1:0]    wstrb,
	input  wire                      wready,
	input  wire                      bvalid,
	output logic                     bready
);
	import lsu_pkg::*;

	lsu_req_t   req_r;
	beat_plan_t plan;
	bus_word_u  first_beat;
	bus_word_u  last_beat;
	logic       busy;
	logic       start_r;
	logic       accept;
	logic       is_load;
	logic       rd_done;
	logic       wr_done;

	// ------------------------------
	// request register
	// ------------------------------
	assign in_allowin = !busy || retire;
	assign accept = in_valid && in_allowin;

	always_ff @(posedge clock) begin
		if (accept) begin
			req_r <= in_req;
		end
	end

	// one request in flight, FSMs kick off the cycle after acceptance
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			start_r <= 1'b0;
			retire <= 1'b0;
		end else begin
			busy <= accept || (busy && !retire);
			start_r <= accept;
			retire <= rd_done || wr_done;
		end
	end

	assign is_load = req_r.kind.lw | req_r.kind.lh | req_r.kind.lhu |
		req_r.kind.lb | req_r.kind.lbu;

	// beats are registered, so the merged value holds through retire
	assign regfile_wen = retire && is_load;
	assign regfile_waddr = req_r.rd;

	lsu_lane_plan u_lane_plan (
		.req  (req_r),
		.plan (plan)
	);

	lsu_read_fsm u_read_fsm (
		.clock      (clock),
		.reset      (reset),
		.start      (start_r && is_load),
		.plan       (plan),
		.arready    (arready),
		.rvalid     (rvalid),
		.rdata      (rdata),
		.arvalid    (arvalid),
		.araddr     (araddr),
		.arsize     (arsize),
		.rready     (rready),
		.first_beat (first_beat),
		.last_beat  (last_beat),
		.done       (rd_done)
	);

	lsu_write_fsm u_write_fsm (
		.clock   (clock),
		.reset   (reset),
		.start   (start_r && !is_load),
		.plan    (plan),
		.awready (awready),
		.wready  (wready),
		.bvalid  (bvalid),
		.awvalid (awvalid),
		.awaddr  (awaddr),
		.awsize  (awsize),
		.wvalid  (wvalid),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.bready  (bready),
		.done    (wr_done)
	);

	lsu_load_merge u_load_merge (
		.kind       (req_r.kind),
		.plan       (plan),
		.first_beat (first_beat),
		.last_beat  (last_beat),
		.load_data  (regfile_wdata)
	);

endmodule

`default_nettype wire

// File: verilog/lsu_write_fsm.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_write_fsm (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       start,
	input  wire lsu_pkg::beat_plan_t  plan,
	input  wire                       awready,
	input  wire                       wready,
	input  wire                       bvalid,
	output logic                      awvalid,
	output logic [`LSU_XLEN-1:0]      awaddr,
	output logic [2:0]                awsize,
	output logic                      wvalid,
	output logic [`LSU_BUS_W-1:0]     wdata,
	output logic [`LSU_LANES-1:0]     wstrb,
	output logic                      bready,
	output logic                      done
);

	typedef enum logic [2:0] {
		wr_idle,
		wr_aw,
		wr_w,
		wr_b,
		wr_second
	} wr_state_t;

	wr_state_t state;
	logic      second;
	logic      last;

	assign last = !plan.need_second || second;

	// bready is always high in wr_b
	assign done = (state == wr_b) && bvalid && last;

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= wr_idle;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			second <= 1'b0;
		end else begin
			case (state)
				wr_idle: if (start) begin
					awvalid <= 1'b1;
					second <= 1'b0;
					state <= wr_aw;
				end
				// data only goes out after its address was taken
				wr_aw: if (awready) begin
					awvalid <= 1'b0;
					wvalid <= 1'b1;
					state <= wr_w;
				end
				wr_w: if (wready) begin
					wvalid <= 1'b0;
					bready <= 1'b1;
					state <= wr_b;
				end
				wr_b: if (bvalid) begin
					bready <= 1'b0;
					state <= last ? wr_idle : wr_second;
				end
				wr_second: begin
					awvalid <= 1'b1;
					second <= 1'b1;
					state <= wr_aw;
				end
				default: state <= wr_idle;
			endcase
		end
	end

	// ------------------------------
	// payload
	// ------------------------------
	always_ff @(posedge clock) begin
		if (state == wr_idle && start) begin
			awaddr <= plan.first_addr;
			awsize <= plan.size;
		end else if (state == wr_second) begin
			awaddr <= plan.second_addr;
		end
		// same rotated word for both beats, only the strobe moves
		if (state == wr_aw && awready) begin
			wdata <= plan.wdata.flat;
			wstrb <= second ? plan.second_strb : plan.first_strb;
		end
	end

endmodule

`default_nettype wire
